/* Makefile */
TOP = rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rv_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/core_pkg.sv */
package core_pkg;

	localparam int xlen          = 32;
	localparam int reg_addr_bits = 5;

	// operation handed from decode to execute.
	typedef struct packed {
		logic [xlen-1:0]          pc;
		rv_isa_pkg::op_class_e    op_class;
		logic [2:0]               funct3;
		logic [reg_addr_bits-1:0] rd;
		logic                     wen;
		logic [xlen-1:0]          op1; // rs1 value after forwarding.
		logic [xlen-1:0]          op2; // rs2 value after forwarding.
		logic [xlen-1:0]          imm;
	} decoded_op_t;

	// result leaving through the retire port.
	typedef struct packed {
		logic [xlen-1:0]          pc;
		logic [reg_addr_bits-1:0] rd;
		logic                     wen;
		logic [xlen-1:0]          value;
		logic                     unsupported;
	} retire_t;

endpackage

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               inst_valid,
	input  logic [core_pkg::xlen-1:0]          inst,
	input  logic [core_pkg::xlen-1:0]          inst_pc,
	output logic                               inst_ready,
	output logic [core_pkg::reg_addr_bits-1:0] rs1,
	output logic [core_pkg::reg_addr_bits-1:0] rs2,
	input  logic [core_pkg::xlen-1:0]          rdata1,
	input  logic [core_pkg::xlen-1:0]          rdata2,
	input  logic                               wb_valid,
	input  logic [core_pkg::reg_addr_bits-1:0] wb_rd,
	input  logic [core_pkg::xlen-1:0]          wb_value,
	input  logic                               flush,
	stage_if.sender                            out
);

	logic [6:0]                         opcode;
	logic [2:0]                         funct3;
	logic [6:0]                         funct7;
	logic [core_pkg::reg_addr_bits-1:0] rd;
	rv_isa_pkg::op_class_e              op_class;
	rv_isa_pkg::format_e                fmt;
	logic [core_pkg::xlen-1:0]          imm;
	logic                               wen;
	logic                               need_rs1;
	logic                               need_rs2;
	logic                               hazard;
	core_pkg::decoded_op_t              dec_op;

	stage_if #(.payload_t(core_pkg::decoded_op_t)) dec_in ();

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign funct7 = inst[31:25];

	always_comb begin
		op_class = rv_isa_pkg::op_unsupported;
		fmt      = rv_isa_pkg::fmt_r;
		case (opcode)
			rv_isa_pkg::opcode_lui: begin
				op_class = rv_isa_pkg::op_lui;
				fmt      = rv_isa_pkg::fmt_u;
			end
			rv_isa_pkg::opcode_auipc: begin
				op_class = rv_isa_pkg::op_auipc;
				fmt      = rv_isa_pkg::fmt_u;
			end
			rv_isa_pkg::opcode_jal: begin
				op_class = rv_isa_pkg::op_jal;
				fmt      = rv_isa_pkg::fmt_j;
			end
			rv_isa_pkg::opcode_jalr: begin
				if (funct3 == 3'b000) op_class = rv_isa_pkg::op_jalr;
				fmt = rv_isa_pkg::fmt_i;
			end
			rv_isa_pkg::opcode_branch: begin
				if (funct3 == 3'b000) op_class = rv_isa_pkg::op_beq; // other branches unsupported.
				fmt = rv_isa_pkg::fmt_b;
			end
			rv_isa_pkg::opcode_op_imm: begin
				if (funct3 == 3'b000) op_class = rv_isa_pkg::op_addi;
				fmt = rv_isa_pkg::fmt_i;
			end
			rv_isa_pkg::opcode_op: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000) op_class = rv_isa_pkg::op_add;
				fmt = rv_isa_pkg::fmt_r;
			end
			rv_isa_pkg::opcode_store: fmt = rv_isa_pkg::fmt_s;
			rv_isa_pkg::opcode_load,
			rv_isa_pkg::opcode_system,
			rv_isa_pkg::opcode_misc_mem: fmt = rv_isa_pkg::fmt_i;
			default: ;
		endcase
	end

	// sign-extended immediate per format.
	always_comb begin
		case (fmt)
			rv_isa_pkg::fmt_i: imm = {{20{inst[31]}}, inst[31:20]};
			rv_isa_pkg::fmt_s: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rv_isa_pkg::fmt_b: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			rv_isa_pkg::fmt_u: imm = {inst[31:12], 12'b0};
			rv_isa_pkg::fmt_j: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:           imm = '0;
		endcase
	end

	assign wen = (fmt == rv_isa_pkg::fmt_r || fmt == rv_isa_pkg::fmt_i ||
		fmt == rv_isa_pkg::fmt_u || fmt == rv_isa_pkg::fmt_j) &&
		op_class != rv_isa_pkg::op_unsupported && rd != '0; // x0 writes are dropped.

	assign need_rs2 = op_class == rv_isa_pkg::op_beq || op_class == rv_isa_pkg::op_add;
	assign need_rs1 = need_rs2 || op_class == rv_isa_pkg::op_jalr ||
		op_class == rv_isa_pkg::op_addi;

	// the op still in the decode register has no value yet.
	assign hazard = out.valid && out.payload.wen &&
		((need_rs1 && rs1 != '0 && out.payload.rd == rs1) ||
		(need_rs2 && rs2 != '0 && out.payload.rd == rs2));

	always_comb begin
		dec_op          = '0;
		dec_op.pc       = inst_pc;
		dec_op.op_class = op_class;
		dec_op.funct3   = funct3;
		dec_op.rd       = rd;
		dec_op.wen      = wen;
		dec_op.imm      = imm;
		dec_op.op1      = (wb_valid && rs1 != '0 && wb_rd == rs1) ? wb_value : rdata1;
		dec_op.op2      = (wb_valid && rs2 != '0 && wb_rd == rs2) ? wb_value : rdata2;
	end

	assign dec_in.valid   = inst_valid & ~hazard & ~flush;
	assign dec_in.payload = dec_op;
	assign inst_ready     = dec_in.ready & ~hazard & ~flush; // no wrong-path accept.

	pipe_reg #(.payload_t(core_pkg::decoded_op_t)) u_dec_reg (
		.clock (clock),
		.reset (reset),
		.flush (flush),
		.in    (dec_in),
		.out   (out)
	);

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic                               clock,
	input  logic                               reset,
	stage_if.receiver                          in,
	output logic                               redirect_valid,
	output logic [core_pkg::xlen-1:0]          redirect_pc,
	output logic                               wb_valid,
	output logic [core_pkg::reg_addr_bits-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0]          wb_value,
	output logic                               reg_we,
	output logic                               retire_valid,
	input  logic                               retire_ready,
	output logic [core_pkg::xlen-1:0]          retire_pc,
	output logic [core_pkg::reg_addr_bits-1:0] retire_rd,
	output logic                               retire_wen,
	output logic [core_pkg::xlen-1:0]          retire_value,
	output logic                               retire_unsupported
);

	core_pkg::decoded_op_t     op;
	core_pkg::retire_t         res;
	logic [core_pkg::xlen-1:0] value;
	logic [core_pkg::xlen-1:0] target;
	logic                      taken;

	stage_if #(.payload_t(core_pkg::retire_t)) ex_res ();
	stage_if #(.payload_t(core_pkg::retire_t)) retire_q ();

	assign op = in.payload;

	always_comb begin
		case (op.op_class)
			rv_isa_pkg::op_lui:   value = op.imm;
			rv_isa_pkg::op_auipc: value = op.pc + op.imm;
			rv_isa_pkg::op_addi:  value = op.op1 + op.imm;
			rv_isa_pkg::op_add:   value = op.op1 + op.op2;
			rv_isa_pkg::op_jal,
			rv_isa_pkg::op_jalr:  value = op.pc + 32'd4; // link address.
			default:              value = '0;
		endcase
	end

	assign target = (op.op_class == rv_isa_pkg::op_jalr) ?
		((op.op1 + op.imm) & ~32'd1) : (op.pc + op.imm);
	assign taken = op.op_class == rv_isa_pkg::op_jal || op.op_class == rv_isa_pkg::op_jalr ||
		(op.op_class == rv_isa_pkg::op_beq && op.op1 == op.op2); // not-taken prediction.

	always_comb begin
		res.pc          = op.pc;
		res.rd          = op.rd;
		res.wen         = op.wen;
		res.value       = value;
		res.unsupported = op.op_class == rv_isa_pkg::op_unsupported;
	end

	assign ex_res.valid   = in.valid;
	assign ex_res.payload = res;
	assign in.ready       = ex_res.ready;

	assign redirect_valid = in.valid & in.ready & taken;
	assign redirect_pc    = target;

	pipe_reg #(.payload_t(core_pkg::retire_t)) u_retire_reg (
		.clock (clock),
		.reset (reset),
		.flush (1'b0),
		.in    (ex_res),
		.out   (retire_q)
	);

	assign retire_q.ready     = retire_ready;
	assign retire_valid       = retire_q.valid;
	assign retire_pc          = retire_q.payload.pc;
	assign retire_rd          = retire_q.payload.rd;
	assign retire_wen         = retire_q.payload.wen;
	assign retire_value       = retire_q.payload.value;
	assign retire_unsupported = retire_q.payload.unsupported;

	// pending write, forwarded to decode until it lands.
	assign wb_valid = retire_q.valid & retire_q.payload.wen;
	assign wb_rd    = retire_q.payload.rd;
	assign wb_value = retire_q.payload.value;
	assign reg_we   = wb_valid & retire_ready;

endmodule

/* hdl/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     flush,
	stage_if.receiver in,
	stage_if.sender   out
);

	logic     valid_q;
	payload_t data_q;

	// take a new entry when empty or when the current one leaves.
	assign in.ready = ~valid_q | out.ready;

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_q <= 1'b0;
		end else if (in.ready) begin
			valid_q <= in.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in.valid && in.ready) begin
			data_q <= in.payload;
		end
	end

	assign out.valid   = valid_q;
	assign out.payload = data_q;

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [core_pkg::reg_addr_bits-1:0] rs1,
	input  logic [core_pkg::reg_addr_bits-1:0] rs2,
	output logic [core_pkg::xlen-1:0]          rdata1,
	output logic [core_pkg::xlen-1:0]          rdata2,
	input  logic                               we,
	input  logic [core_pkg::reg_addr_bits-1:0] waddr,
	input  logic [core_pkg::xlen-1:0]          wdata
);

	logic [core_pkg::xlen-1:0] regs [1:31]; // x0 has no storage.

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               inst_valid,
	input  logic [core_pkg::xlen-1:0]          inst,
	input  logic [core_pkg::xlen-1:0]          inst_pc,
	output logic                               inst_ready,
	output logic                               redirect_valid,
	output logic [core_pkg::xlen-1:0]          redirect_pc,
	output logic                               retire_valid,
	input  logic                               retire_ready,
	output logic [core_pkg::xlen-1:0]          retire_pc,
	output logic [core_pkg::reg_addr_bits-1:0] retire_rd,
	output logic                               retire_wen,
	output logic [core_pkg::xlen-1:0]          retire_value,
	output logic                               retire_unsupported
);

	logic [core_pkg::reg_addr_bits-1:0] rs1;
	logic [core_pkg::reg_addr_bits-1:0] rs2;
	logic [core_pkg::xlen-1:0]          rdata1;
	logic [core_pkg::xlen-1:0]          rdata2;
	logic                               wb_valid;
	logic [core_pkg::reg_addr_bits-1:0] wb_rd;
	logic [core_pkg::xlen-1:0]          wb_value;
	logic                               reg_we;

	stage_if #(.payload_t(core_pkg::decoded_op_t)) dec_to_ex ();

	decode_stage u_decode (
		.clock      (clock),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.inst_ready (inst_ready),
		.rs1        (rs1),
		.rs2        (rs2),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_value   (wb_value),
		.flush      (redirect_valid), // drop the op behind a taken branch.
		.out        (dec_to_ex)
	);

	reg_file u_reg_file (
		.clock  (clock),
		.reset  (reset),
		.rs1    (rs1),
		.rs2    (rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (reg_we),
		.waddr  (retire_rd),
		.wdata  (retire_value)
	);

	execute_stage u_execute (
		.clock              (clock),
		.reset              (reset),
		.in                 (dec_to_ex),
		.redirect_valid     (redirect_valid),
		.redirect_pc        (redirect_pc),
		.wb_valid           (wb_valid),
		.wb_rd              (wb_rd),
		.wb_value           (wb_value),
		.reg_we             (reg_we),
		.retire_valid       (retire_valid),
		.retire_ready       (retire_ready),
		.retire_pc          (retire_pc),
		.retire_rd          (retire_rd),
		.retire_wen         (retire_wen),
		.retire_value       (retire_value),
		.retire_unsupported (retire_unsupported)
	);

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes of the supported subset.
	localparam logic [6:0] opcode_lui      = 7'b0110111;
	localparam logic [6:0] opcode_auipc    = 7'b0010111;
	localparam logic [6:0] opcode_jal      = 7'b1101111;
	localparam logic [6:0] opcode_jalr     = 7'b1100111;
	localparam logic [6:0] opcode_branch   = 7'b1100011;
	localparam logic [6:0] opcode_load     = 7'b0000011;
	localparam logic [6:0] opcode_store    = 7'b0100011;
	localparam logic [6:0] opcode_op_imm   = 7'b0010011;
	localparam logic [6:0] opcode_op       = 7'b0110011;
	localparam logic [6:0] opcode_system   = 7'b1110011; // ecall, mret and csr.
	localparam logic [6:0] opcode_misc_mem = 7'b0001111; // fence.i.

	// what execute does with an instruction.
	typedef enum logic [2:0] {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_beq,
		op_addi,
		op_add,
		op_unsupported
	} op_class_e;

	// encoding format, selects the immediate layout.
	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} format_e;

endpackage

/* hdl/stage_if.sv */
`timescale 1ns/1ps

interface stage_if #(
	parameter type payload_t = logic
);
	logic     valid;
	logic     ready;
	payload_t payload;

	modport sender (
		output valid,
		output payload,
		input  ready
	);

	modport receiver (
		input  valid,
		input  payload,
		output ready
	);
endinterface

/* rv_core.f */
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/pipe_reg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv_core.sv
test/rv_core_tb.sv

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

	logic        clock = 1'b0;
	logic        reset;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic        inst_ready;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic        retire_valid;
	logic        retire_ready;
	logic [31:0] retire_pc;
	logic [4:0]  retire_rd;
	logic        retire_wen;
	logic [31:0] retire_value;
	logic        retire_unsupported;

	rv_isa_pkg::op_class_e prog_cls [64];
	logic [31:0]           prog_word [64];
	logic [31:0]           prog_imm [64];
	logic [4:0]            prog_rd [64];
	logic [4:0]            prog_rs1 [64];
	logic [4:0]            prog_rs2 [64];
	int                    prog_len;
	logic [31:0]           prog_end;
	logic [31:0]           fetch_pc;
	core_pkg::retire_t     exp_q [$];
	logic [31:0]           redir_q [$];
	core_pkg::retire_t     head;
	int                    errors = 0;
	int                    retired = 0;
	int                    budget = 0;

	rv_core UUT (.*);

	always #10 clock = ~clock;

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic report_fault(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	function automatic logic [31:0] encode(input rv_isa_pkg::op_class_e cls,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [31:0] imm, input logic [31:0] raw);
		case (cls)
			rv_isa_pkg::op_lui:   return {imm[31:12], rd, rv_isa_pkg::opcode_lui};
			rv_isa_pkg::op_auipc: return {imm[31:12], rd, rv_isa_pkg::opcode_auipc};
			rv_isa_pkg::op_jal:
				return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::opcode_jal};
			rv_isa_pkg::op_jalr:  return {imm[11:0], rs1, 3'b000, rd, rv_isa_pkg::opcode_jalr};
			rv_isa_pkg::op_beq:
				return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
					rv_isa_pkg::opcode_branch};
			rv_isa_pkg::op_addi:  return {imm[11:0], rs1, 3'b000, rd, rv_isa_pkg::opcode_op_imm};
			rv_isa_pkg::op_add:   return {7'd0, rs2, rs1, 3'b000, rd, rv_isa_pkg::opcode_op};
			default:              return raw; // unsupported words are given whole.
		endcase
	endfunction

	task automatic add_inst(input rv_isa_pkg::op_class_e cls, input int rd, input int rs1,
		input int rs2, input int imm, input logic [31:0] raw);
		prog_cls[prog_len]  = cls;
		prog_rd[prog_len]   = rd[4:0];
		prog_rs1[prog_len]  = rs1[4:0];
		prog_rs2[prog_len]  = rs2[4:0];
		prog_imm[prog_len]  = imm;
		prog_word[prog_len] = encode(cls, rd[4:0], rs1[4:0], rs2[4:0], imm, raw);
		prog_len++;
	endtask

	task automatic load_program(input int t);
		prog_len = 0;
		case (t)
			0: begin
				add_inst(rv_isa_pkg::op_lui, 1, 0, 0, 32'h12345000, 0);
				add_inst(rv_isa_pkg::op_auipc, 2, 0, 0, 32'h00001000, 0);
				add_inst(rv_isa_pkg::op_addi, 3, 1, 0, 32'h678, 0); // lui forwarded from retire.
				add_inst(rv_isa_pkg::op_add, 4, 3, 2, 0, 0);
				add_inst(rv_isa_pkg::op_addi, 5, 4, 0, -1, 0);
				add_inst(rv_isa_pkg::op_add, 6, 5, 5, 0, 0);
				add_inst(rv_isa_pkg::op_addi, 0, 1, 0, 5, 0); // write to x0.
				add_inst(rv_isa_pkg::op_add, 7, 0, 0, 0, 0);
				add_inst(rv_isa_pkg::op_addi, 8, 7, 0, 3, 0);
			end
			1: begin
				add_inst(rv_isa_pkg::op_addi, 1, 0, 0, 8, 0);
				add_inst(rv_isa_pkg::op_beq, 0, 1, 1, 8, 0); // taken.
				add_inst(rv_isa_pkg::op_addi, 2, 0, 0, 1, 0);
				add_inst(rv_isa_pkg::op_addi, 3, 0, 0, 2, 0);
				add_inst(rv_isa_pkg::op_beq, 0, 1, 0, 8, 0); // falls through.
				add_inst(rv_isa_pkg::op_jal, 4, 0, 0, 8, 0);
				add_inst(rv_isa_pkg::op_addi, 5, 0, 0, 9, 0);
				add_inst(rv_isa_pkg::op_addi, 6, 0, 0, 41, 0);
				add_inst(rv_isa_pkg::op_jalr, 7, 6, 0, 0, 0); // bit 0 of the target drops.
				add_inst(rv_isa_pkg::op_addi, 8, 0, 0, 7, 0);
				add_inst(rv_isa_pkg::op_add, 9, 4, 7, 0, 0);
				add_inst(rv_isa_pkg::op_jal, 0, 0, 0, 8, 0);
				add_inst(rv_isa_pkg::op_addi, 10, 0, 0, 1, 0);
				add_inst(rv_isa_pkg::op_addi, 11, 0, 0, 5, 0);
			end
			default: begin
				add_inst(rv_isa_pkg::op_addi, 7, 0, 0, 77, 0);
				add_inst(rv_isa_pkg::op_unsupported, 7, 0, 0, 0,
					{12'd0, 5'd0, 3'b010, 5'd7, rv_isa_pkg::opcode_load});
				add_inst(rv_isa_pkg::op_unsupported, 4, 0, 7, 0,
					{7'd0, 5'd7, 5'd0, 3'b010, 5'd4, rv_isa_pkg::opcode_store});
				add_inst(rv_isa_pkg::op_unsupported, 0, 0, 0, 0, 32'h00000073);
				add_inst(rv_isa_pkg::op_unsupported, 7, 7, 0, 0,
					{12'h300, 5'd7, 3'b001, 5'd7, rv_isa_pkg::opcode_system});
				add_inst(rv_isa_pkg::op_addi, 8, 7, 0, 0, 0);
				add_inst(rv_isa_pkg::op_add, 9, 8, 7, 0, 0);
			end
		endcase
		prog_end = prog_len * 4;
	endtask

	// in-order reference run of the loaded program.
	task automatic golden_run();
		logic [31:0]       gregs [32];
		logic [31:0]       pc;
		logic [31:0]       next;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       value;
		logic [5:0]        i;
		logic              taken;
		int                steps;
		core_pkg::retire_t rec;
		gregs = '{default: '0};
		pc    = '0;
		steps = 0;
		while (pc < prog_end && steps < 200) begin
			i     = pc[7:2];
			a     = gregs[prog_rs1[i]];
			b     = gregs[prog_rs2[i]];
			next  = pc + 32'd4;
			value = '0;
			taken = 1'b0;
			case (prog_cls[i])
				rv_isa_pkg::op_lui:   value = prog_imm[i];
				rv_isa_pkg::op_auipc: value = pc + prog_imm[i];
				rv_isa_pkg::op_addi:  value = a + prog_imm[i];
				rv_isa_pkg::op_add:   value = a + b;
				rv_isa_pkg::op_jal: begin
					value = pc + 32'd4;
					next  = pc + prog_imm[i];
					taken = 1'b1;
				end
				rv_isa_pkg::op_jalr: begin
					value = pc + 32'd4;
					next  = (a + prog_imm[i]) & ~32'd1;
					taken = 1'b1;
				end
				rv_isa_pkg::op_beq: begin
					taken = a == b;
					if (taken) next = pc + prog_imm[i];
				end
				default: ;
			endcase
			rec.pc          = pc;
			rec.rd          = prog_rd[i];
			rec.wen         = prog_cls[i] != rv_isa_pkg::op_unsupported &&
				prog_cls[i] != rv_isa_pkg::op_beq && prog_rd[i] != '0;
			rec.value       = value;
			rec.unsupported = prog_cls[i] == rv_isa_pkg::op_unsupported;
			if (rec.wen) gregs[prog_rd[i]] = value;
			exp_q.push_back(rec);
			if (taken) redir_q.push_back(next);
			pc = next;
			steps++;
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			fetch_pc <= '0;
		end else if (redirect_valid) begin
			fetch_pc <= redirect_pc;
		end else if (inst_valid && inst_ready) begin
			fetch_pc <= fetch_pc + 32'd4;
		end
	end

	// fetch model and retire back-pressure.
	always @(negedge clock) begin
		inst_valid   = fetch_pc < prog_end;
		inst         = prog_word[fetch_pc[7:2]];
		inst_pc      = fetch_pc;
		retire_ready = ($urandom % 4) != 0;
	end

	always @(posedge clock) begin
		if (!reset && retire_valid && retire_ready) begin
			retired++;
			if (exp_q.size() == 0) begin
				report_fault($sformatf("pc %h retired with nothing left to retire", retire_pc));
			end else begin
				head = exp_q.pop_front();
				assert (retire_pc == head.pc) else report_mismatch("retire_pc", retire_pc, head.pc);
				assert (retire_wen == head.wen)
					else report_mismatch("retire_wen", 32'(retire_wen), 32'(head.wen));
				assert (retire_unsupported == head.unsupported)
					else report_mismatch("retire_unsupported", 32'(retire_unsupported),
						32'(head.unsupported));
				if (head.wen) begin
					assert (retire_rd == head.rd)
						else report_mismatch("retire_rd", 32'(retire_rd), 32'(head.rd));
					assert (retire_value == head.value)
						else report_mismatch("retire_value", retire_value, head.value);
				end
			end
		end
		if (!reset && redirect_valid) begin
			if (redir_q.size() == 0) begin
				report_fault($sformatf("redirect to %h that no jump or branch asked for",
					redirect_pc));
			end else begin
				assert (redirect_pc == redir_q[0])
					else report_mismatch("redirect_pc", redirect_pc, redir_q[0]);
				void'(redir_q.pop_front());
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) redirect_valid |-> !inst_ready)
		else report_fault("an instruction was accepted while a redirect was pending");

	task automatic run_test(input int t, input string name);
		int start_errors;
		int start_retired;
		start_errors  = errors;
		start_retired = retired;
		reset = 1'b1;
		load_program(t);
		golden_run();
		repeat (8) @(negedge clock);
		reset = 1'b0;
		assert (!retire_valid && !redirect_valid)
			else report_fault("retire or redirect active right after reset");
		while (exp_q.size() != 0) @(negedge clock);
		repeat (12) @(negedge clock); // room for a stray retire to show up.
		if (redir_q.size() != 0) report_fault("an expected redirect never happened");
		redir_q.delete();
		$display("test %0d (%s): %0d retired, %0d errors", t, name,
			retired - start_retired, errors - start_errors);
	endtask

	initial begin
		int total;
		total        = 0;
		reset        = 1'b1;
		inst_valid   = 1'b0;
		inst         = '0;
		inst_pc      = '0;
		retire_ready = 1'b0;
		prog_end     = '0;
		void'($urandom(38));
		for (int t = 0; t < 3; t++) begin
			load_program(t);
			golden_run();
			total += exp_q.size() * 40 + 20;
			exp_q.delete();
			redir_q.delete();
		end
		budget = total;
		run_test(0, "alu ops, forwarding and x0");
		run_test(1, "branches and jumps");
		run_test(2, "unsupported instructions");
		$display("tests: 3, retired: %0d, errors: %0d", retired, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		wait (budget != 0);
		repeat (budget) @(posedge clock);
		$display("timeout: the tests did not finish within %0d cycles", budget);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
